/* common/snd_consts.svh */
/*
 * Constants for the sound board: region codes of the sound CPU map,
 * work RAM size, FM busy window and FM timer register numbers.
 * Include wherever a value is needed; the include dir is common/.
 */
`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

// region codes, order follows the memory map
`define SND_REGION_ROM     3'd0   // 8000-FFFF
`define SND_REGION_LATCH   3'd1   // 0000-1FFF
`define SND_REGION_FM      3'd2   // 2000-3FFF
`define SND_REGION_IRQCLR  3'd3   // 4000-5FFF
`define SND_REGION_RAM     3'd4   // 6000-7FFF, aliased every 2 KB

// work RAM
`define SND_RAM_AW         11     // 2 KB

// FM chip busy window after a data write, in cen_fm ticks
`define FM_BUSY_TICKS      32

// FM register numbers
`define FM_REG_TA_HI       8'h10  // timer A bits 9..2
`define FM_REG_TA_LO       8'h11  // timer A bits 1..0
`define FM_REG_TB          8'h12  // timer B, 8 bits
`define FM_REG_CTRL        8'h14  // load/start and flag clear

`endif

/* common/snd_pkg.sv */
/*
 * Types shared across the sound board: one sound CPU bus cycle,
 * the decoded region and the FM status byte.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

`include "snd_consts.svh"

package snd_pkg;

    // one sound CPU bus cycle as seen by the board
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;    // 1 = read
        logic        wr;     // single clock write strobe
        logic [7:0]  wdata;
    } snd_bus_req;

    // memory map regions
    typedef enum logic [2:0] {
        REGION_ROM    = `SND_REGION_ROM,
        REGION_LATCH  = `SND_REGION_LATCH,
        REGION_FM     = `SND_REGION_FM,
        REGION_IRQCLR = `SND_REGION_IRQCLR,
        REGION_RAM    = `SND_REGION_RAM
    } snd_region;

    // FM status byte, msb first
    typedef struct packed {
        logic       busy;    // bit 7, write in progress
        logic [4:0] zero;    // always read as 0
        logic       flag_b;  // bit 1, timer B overflow
        logic       flag_a;  // bit 0, timer A overflow
    } fm_status;

endpackage

`default_nettype wire

/* logic/snd_work_ram.sv */
/*
 * Sound CPU work RAM, 2 KB.
 * Single port, write on the strobe, read data registered so it is
 * valid one clock after the address.
 */
`default_nettype none

`include "snd_consts.svh"

module snd_work_ram (
    input  wire                   clk,
    input  wire                   we,
    input  wire [`SND_RAM_AW-1:0] addr,
    input  wire [7:0]             wdata,
    output logic [7:0]            rdata
);

    logic [7:0] mem [0:(1 << `SND_RAM_AW) - 1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];   // old data on a same cycle write
    end

endmodule

`default_nettype wire

/* logic/snd_irq_latch.sv */
/*
 * Interrupt request from the main CPU to the sound CPU.
 * A rising edge of the request pulls irq_n low until the sound CPU
 * writes the clear port. Clear beats a new edge in the same cycle.
 */
`default_nettype none

module snd_irq_latch (
    input  wire  clk,
    input  wire  reset,
    input  wire  req_in,   // level from main CPU
    input  wire  clr,      // write strobe, IRQCLR region
    output logic irq_n
);

    logic req_q;     // request one clock ago
    logic req_rise;

    assign req_rise = req_in && !req_q;   // held level fires once

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
            irq_n <= 1'b1;
        end else begin
            req_q <= req_in;
            if (clr) begin
                irq_n <= 1'b1;            // clear first
            end else if (req_rise) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* fm/fm_regs.sv */
/*
 * Register side of the FM chip.
 * Address and data writes, a 10-bit timer A and an 8-bit timer B with
 * a divide-by-16 prescaler, overflow flags and the busy window.
 * Timers and busy count only on cen_fm; status is read by the CPU.
 */
`default_nettype none

`include "snd_consts.svh"

module fm_regs import snd_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        cen_fm,   // timer tick
    input  wire        we,       // FM region write strobe
    input  wire        a0,       // 0 = register number, 1 = data
    input  wire  [7:0] wdata,
    output fm_status   status
);

    localparam int BUSY_W = $clog2(`FM_BUSY_TICKS + 1);

    logic [7:0]        sel;        // selected register number
    logic              addr_wr;
    logic              data_wr;
    logic              ctrl_wr;

    // timer A
    logic [9:0]        ta_val;     // reload value
    logic [9:0]        ta_cnt;
    logic              ta_run;
    logic              ta_ovf;

    // timer B
    logic [7:0]        tb_val;
    logic [7:0]        tb_cnt;
    logic [3:0]        tb_pre;     // /16 prescaler
    logic              tb_run;
    logic              tb_step;    // prescaler wraps this tick
    logic              tb_ovf;

    logic              flag_a;
    logic              flag_b;
    logic              busy;
    logic [BUSY_W-1:0] busy_cnt;   // ticks left in busy window

    assign addr_wr = we && !a0;
    assign data_wr = we && a0;
    assign ctrl_wr = data_wr && sel == `FM_REG_CTRL;

    // counters run up and wrap at all ones
    assign ta_ovf  = cen_fm && ta_run && ta_cnt == 10'h3ff;
    assign tb_step = cen_fm && tb_run && tb_pre == 4'hf;
    assign tb_ovf  = tb_step && tb_cnt == 8'hff;

    // register number
    always_ff @(posedge clk) begin
        if (reset) begin
            sel <= 8'h00;
        end else if (addr_wr) begin
            sel <= wdata;
        end
    end

    // timer values
    always_ff @(posedge clk) begin
        if (reset) begin
            ta_val <= 10'd0;
            tb_val <= 8'd0;
        end else if (data_wr) begin
            case (sel)
                `FM_REG_TA_HI: ta_val[9:2] <= wdata;
                `FM_REG_TA_LO: ta_val[1:0] <= wdata[1:0];
                `FM_REG_TB:    tb_val      <= wdata;
                default: ;                 // other registers not modelled
            endcase
        end
    end

    // timer A, control bit 0 loads and starts
    always_ff @(posedge clk) begin
        if (reset) begin
            ta_run <= 1'b0;
            ta_cnt <= 10'd0;
        end else if (ctrl_wr) begin
            ta_run <= wdata[0];            // bit 0 low stops it
            if (wdata[0]) begin
                ta_cnt <= ta_val;
            end
        end else if (cen_fm && ta_run) begin
            ta_cnt <= ta_ovf ? ta_val : ta_cnt + 10'd1;   // reload on wrap
        end
    end

    // timer B, control bit 1, steps once per 16 ticks
    always_ff @(posedge clk) begin
        if (reset) begin
            tb_run <= 1'b0;
            tb_cnt <= 8'd0;
            tb_pre <= 4'd0;
        end else if (ctrl_wr) begin
            tb_run <= wdata[1];
            if (wdata[1]) begin
                tb_cnt <= tb_val;
                tb_pre <= 4'd0;            // full first period
            end
        end else if (cen_fm && tb_run) begin
            tb_pre <= tb_pre + 4'd1;
            if (tb_step) begin
                tb_cnt <= tb_ovf ? tb_val : tb_cnt + 8'd1;
            end
        end
    end

    // overflow flags, clear by control bits 4 and 5 wins
    always_ff @(posedge clk) begin
        if (reset) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ta_ovf) begin
                flag_a <= 1'b1;
            end
            if (tb_ovf) begin
                flag_b <= 1'b1;
            end
            if (ctrl_wr && wdata[4]) begin
                flag_a <= 1'b0;
            end
            if (ctrl_wr && wdata[5]) begin
                flag_b <= 1'b0;
            end
        end
    end

    // busy window after each data write
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;              // restarts if already busy
            busy_cnt <= BUSY_W'(`FM_BUSY_TICKS);
        end else if (busy && cen_fm) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == BUSY_W'(1)) begin
                busy <= 1'b0;              // last tick of the window
            end
        end
    end

    always_comb begin
        status        = '0;
        status.busy   = busy;
        status.flag_b = flag_b;
        status.flag_a = flag_a;
    end

endmodule

`default_nettype wire

/* sound/snd_bus_decode.sv */
/*
 * Sound CPU address decoder and read multiplexer.
 * Splits the 16-bit bus into ROM, latch, FM, IRQ clear and RAM,
 * qualifies the write strobe per region and returns read data
 * two clocks after the address, 0xFF where nothing answers.
 */
`default_nettype none

module snd_bus_decode import snd_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  snd_bus_req  req,
    input  wire  [7:0]  rom_data,
    input  wire  [7:0]  ram_rdata,
    input  wire  [7:0]  latch,
    input  fm_status    fm_stat,
    output logic        rom_cs,
    output logic [14:0] rom_addr,
    output logic        ram_we,
    output logic        fm_we,
    output logic        irq_clr,
    output logic [7:0]  rdata
);

    snd_region region;
    logic      rd_rom, rd_latch, rd_fm, rd_ram;   // read selects, one-hot
    logic      s1_ram;                            // stage 1 holds a RAM read
    logic [7:0] s1_data;                          // stage 1 data, non-RAM

    // region from the top address bits
    always_comb begin
        if (req.addr[15]) begin
            region = REGION_ROM;
        end else begin
            case (req.addr[14:13])
                2'b00:   region = REGION_LATCH;
                2'b01:   region = REGION_FM;
                2'b10:   region = REGION_IRQCLR;
                default: region = REGION_RAM;
            endcase
        end
    end

    assign rom_cs   = req.addr[15];     // plain level, no rnw
    assign rom_addr = req.addr[14:0];

    // write strobes per region
    assign ram_we  = req.wr && !req.rnw && region == REGION_RAM;
    assign fm_we   = req.wr && !req.rnw && region == REGION_FM;
    assign irq_clr = req.wr && !req.rnw && region == REGION_IRQCLR;

    // reads only; IRQCLR has no read port
    assign rd_rom   = req.rnw && region == REGION_ROM;
    assign rd_latch = req.rnw && region == REGION_LATCH;
    assign rd_fm    = req.rnw && region == REGION_FM;
    assign rd_ram   = req.rnw && region == REGION_RAM;

    // stage 1, lines up with the RAM's own read register
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_ram  <= 1'b0;
            s1_data <= 8'hff;
        end else begin
            s1_ram <= rd_ram;
            case (1'b1)
                rd_rom:   s1_data <= rom_data;
                rd_latch: s1_data <= latch;
                rd_fm:    s1_data <= fm_stat;
                default:  s1_data <= 8'hff;   // RAM picked up in stage 2
            endcase
        end
    end

    // stage 2, data to the CPU
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= 8'hff;
        end else begin
            rdata <= s1_ram ? ram_rdata : s1_data;
        end
    end

endmodule

`default_nettype wire

/* sound/snd_board.sv */
/*
 * Sound board top level.
 * The sound CPU bus comes in as a port; this ties together the address
 * decoder, work RAM, main CPU interrupt latch and the FM register block.
 */
`default_nettype none

`include "snd_consts.svh"

module snd_board import snd_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         cen_fm,     // FM clock enable
    input  snd_bus_req  req,        // sound CPU bus
    input  wire         snd_irq,    // request from main CPU
    input  wire  [7:0]  snd_latch,  // byte from main CPU
    input  wire  [7:0]  rom_data,
    output logic        rom_cs,
    output logic [14:0] rom_addr,
    output logic [7:0]  rdata,      // read data to sound CPU
    output logic        irq_n       // to sound CPU, active low
);

    logic       ram_we;
    logic       fm_we;
    logic       irq_clr;
    logic [7:0] ram_rdata;
    fm_status   fm_stat;

    snd_bus_decode u_decode (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .req       ( req       ),
        .rom_data  ( rom_data  ),
        .ram_rdata ( ram_rdata ),
        .latch     ( snd_latch ),
        .fm_stat   ( fm_stat   ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .ram_we    ( ram_we    ),
        .fm_we     ( fm_we     ),
        .irq_clr   ( irq_clr   ),
        .rdata     ( rdata     )
    );

    // low address bits only, RAM repeats through its 8 KB region
    snd_work_ram u_ram (
        .clk   ( clk                           ),
        .we    ( ram_we                        ),
        .addr  ( req.addr[`SND_RAM_AW-1:0]     ),
        .wdata ( req.wdata                     ),
        .rdata ( ram_rdata                     )
    );

    snd_irq_latch u_irq (
        .clk    ( clk     ),
        .reset  ( reset   ),
        .req_in ( snd_irq ),
        .clr    ( irq_clr ),
        .irq_n  ( irq_n   )
    );

    fm_regs u_fm (
        .clk    ( clk         ),
        .reset  ( reset       ),
        .cen_fm ( cen_fm      ),
        .we     ( fm_we       ),
        .a0     ( req.addr[0] ),   // 0 = address, 1 = data
        .wdata  ( req.wdata   ),
        .status ( fm_stat     )
    );

endmodule

`default_nettype wire

/* testbench/tb_snd_board.sv */
/*
 * Testbench for the sound board. Plays the sound CPU on the bus, supplies
 * ROM data, the main CPU latch and interrupt, and the cen_fm ticks.
 * Reads are checked against a model of the memory map and FM status.
 */
`default_nettype none

`include "snd_consts.svh"

module tb_snd_board import snd_pkg::*; ();

    localparam int MAX_CYCLES  = 20000;   // worst case run is about 6600 cycles
    localparam int KIND_BYTE   = 0;
    localparam int KIND_STATUS = 1;
    localparam int KIND_BIT    = 2;
    localparam int KIND_ADDR   = 3;

    logic        clk = 1'b0;
    logic        reset;
    logic        cen_fm = 1'b0;
    snd_bus_req  req;
    logic        snd_irq;
    logic [7:0]  snd_latch;
    wire  [7:0]  rom_data;
    logic        rom_cs;
    logic [14:0] rom_addr;
    logic [7:0]  rdata;
    logic        irq_n;

    logic [1:0]  cen_div = 2'd0;
    int          ticks = 0;       // cen_fm pulses seen by the DUT
    int          cycles = 0;
    int          seed = 18255;
    int          t_fm;            // tick count right after the last FM data write

    logic [7:0]  shadow [0:(1 << `SND_RAM_AW) - 1];   // work RAM model
    fm_status    stat_model;                          // expected FM status

    // handoff to the compare process
    int          cmp_req = 0;     // requests posted
    int          cmp_ack = 0;     // requests checked
    int          cmp_kind;
    string       cmp_name;
    logic [15:0] cmp_exp;
    logic [15:0] cmp_got;

    snd_board u_snd_board (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen_fm    ( cen_fm    ),
        .req       ( req       ),
        .snd_irq   ( snd_irq   ),
        .snd_latch ( snd_latch ),
        .rom_data  ( rom_data  ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .rdata     ( rdata     ),
        .irq_n     ( irq_n     )
    );

    assign rom_data = rom_fn(rom_addr);   // ROM answers at once

    always #4 clk = ~clk;

    // one cen_fm pulse every 4 clocks
    always @(negedge clk) begin
        cen_div <= cen_div + 2'd1;
        cen_fm  <= cen_div == 2'd3;
    end

    always @(posedge clk) begin
        if (cen_fm) ticks <= ticks + 1;
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
            abort_run($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
    end

    // each byte depends on the whole address
    function automatic logic [7:0] rom_fn(input logic [14:0] a);
        return a[7:0] ^ a[14:7] ^ 8'h5a;
    endfunction

    function automatic snd_region region_of(input logic [15:0] a);
        if (a[15]) return REGION_ROM;
        case (a[14:13])
            2'b00:   return REGION_LATCH;
            2'b01:   return REGION_FM;
            2'b10:   return REGION_IRQCLR;
            default: return REGION_RAM;
        endcase
    endfunction

    // expected read byte for an address
    function automatic logic [7:0] expected_read(input logic [15:0] a);
        case (region_of(a))
            REGION_ROM:   return rom_fn(a[14:0]);
            REGION_LATCH: return snd_latch;
            REGION_FM:    return stat_model;
            REGION_RAM:   return shadow[a[`SND_RAM_AW-1:0]];   // 2 KB alias
            default:      return 8'hff;                         // nothing answers
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t: %s expected %02h got %02h",
                                $time, name, exp, got));
    endtask

    task automatic check_status(input fm_status exp, input fm_status got);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t: fm status expected %08b got %08b",
                                $time, exp, got));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t: %s expected %0b got %0b", $time, name, exp, got));
    endtask

    task automatic check_rom_addr(input logic [14:0] exp, input logic [14:0] got);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t: rom_addr expected %04h got %04h",
                                $time, exp, got));
    endtask

    // compare process, one check per request
    always begin
        wait (cmp_ack != cmp_req);
        case (cmp_kind)
            KIND_BYTE:   check_byte(cmp_name, cmp_exp[7:0], cmp_got[7:0]);
            KIND_STATUS: check_status(fm_status'(cmp_exp[7:0]), fm_status'(cmp_got[7:0]));
            KIND_BIT:    check_bit(cmp_name, cmp_exp[0], cmp_got[0]);
            default:     check_rom_addr(cmp_exp[14:0], cmp_got[14:0]);
        endcase
        cmp_ack = cmp_ack + 1;
    end

    task automatic compare(input int kind, input string name,
                           input logic [15:0] exp, input logic [15:0] got);
        cmp_kind = kind;
        cmp_name = name;
        cmp_exp  = exp;
        cmp_got  = got;
        cmp_req  = cmp_req + 1;
        wait (cmp_ack == cmp_req);
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk);
        req = '{addr: a, rnw: 1'b0, wr: 1'b1, wdata: d};
        @(negedge clk);
        req.wr  = 1'b0;   // one clock strobe
        req.rnw = 1'b1;
        if (region_of(a) == REGION_RAM) shadow[a[`SND_RAM_AW-1:0]] = d;
    endtask

    // address held three cycles, data taken in the third
    task automatic bus_read(input logic [15:0] a, output logic [7:0] d, output int t_drive);
        @(negedge clk);
        req = '{addr: a, rnw: 1'b1, wr: 1'b0, wdata: 8'h00};
        t_drive = ticks;
        repeat (2) @(negedge clk);
        d = rdata;
    endtask

    task automatic read_check(input logic [15:0] a);
        logic [7:0] d;
        int         t;
        bus_read(a, d, t);
        compare(region_of(a) == REGION_FM ? KIND_STATUS : KIND_BYTE, "rdata",
                {8'h00, expected_read(a)}, {8'h00, d});
    endtask

    task automatic fm_write(input logic [7:0] reg_num, input logic [7:0] val);
        bus_write(16'h2000, reg_num);   // a0 = 0, register number
        bus_write(16'h2001, val);
        stat_model.busy = 1'b1;
        t_fm = ticks;
    endtask

    // poll one status bit until it reaches want, inside a tick window around period
    task automatic poll_status(input int bitn, input logic want, input int period,
                               input int slack);
        logic [7:0] d;
        int         t;
        do begin
            bus_read(16'h2000, d, t);
            if (d[bitn] !== want && t - t_fm > period + slack)
                abort_run($sformatf("status bit %0d not %0b after %0d ticks, expected at %0d",
                                    bitn, want, t - t_fm, period));
        end while (d[bitn] !== want);
        if (t - t_fm + 1 < period - slack)
            abort_run($sformatf("status bit %0d went %0b after %0d ticks, expected at %0d",
                                bitn, want, t - t_fm, period));
    endtask

    initial begin
        int          r;
        int          i;
        int          period;
        logic [15:0] a;
        logic [9:0]  ta_load;
        logic [7:0]  tb_load;
        logic [10:0] used [$];    // RAM offsets written so far
        reset      = 1'b1;
        req        = '{addr: 16'h0000, rnw: 1'b1, wr: 1'b0, wdata: 8'h00};
        snd_irq    = 1'b0;
        snd_latch  = 8'h00;
        stat_model = '0;
        t_fm       = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        compare(KIND_BIT, "irq_n", 16'd1, {15'd0, irq_n});
        compare(KIND_BYTE, "rdata", 16'h00ff, {8'h00, rdata});
        read_check(16'h2000);     // FM status idle

        // ROM with chip select and address
        repeat (40) begin
            r = $random(seed);
            a = {1'b1, r[14:0]};
            read_check(a);
            compare(KIND_BIT, "rom_cs", 16'd1, {15'd0, rom_cs});
            compare(KIND_ADDR, "rom_addr", {1'b0, a[14:0]}, {1'b0, rom_addr});
        end
        @(negedge clk);
        r = $random(seed);
        snd_latch = r[7:0];
        repeat (20) begin
            r = $random(seed);
            read_check({3'b000, r[12:0]});
            compare(KIND_BIT, "rom_cs", 16'd0, {15'd0, rom_cs});
        end
        repeat (10) begin         // IRQ clear port reads as FF
            r = $random(seed);
            read_check({3'b010, r[12:0]});
        end

        // work RAM, whole 8 KB region so the aliases get hit
        repeat (200) begin
            r = $random(seed);
            a = {3'b011, r[12:0]};
            bus_write(a, r[23:16]);
            used.push_back(a[10:0]);
        end
        repeat (200) begin
            r = $random(seed);
            i = int'(r[7:0]) % used.size();
            read_check({3'b011, r[12:11], used[i]});
        end

        // interrupt latch
        @(negedge clk);
        snd_irq = 1'b1;
        @(negedge clk);
        compare(KIND_BIT, "irq_n", 16'd0, {15'd0, irq_n});
        bus_write(16'h4000, 8'h00);
        repeat (3) @(negedge clk);
        compare(KIND_BIT, "irq_n", 16'd1, {15'd0, irq_n});   // level held, no new edge
        snd_irq = 1'b0;
        repeat (2) @(negedge clk);
        snd_irq = 1'b1;           // edge and clear in one cycle
        req = '{addr: 16'h4000, rnw: 1'b0, wr: 1'b1, wdata: 8'h00};
        @(negedge clk);
        req.wr  = 1'b0;
        req.rnw = 1'b1;
        compare(KIND_BIT, "irq_n", 16'd1, {15'd0, irq_n});
        repeat (3) @(negedge clk);
        compare(KIND_BIT, "irq_n", 16'd1, {15'd0, irq_n});

        // busy window, register 0x20 has no timer
        fm_write(8'h20, 8'h5a);
        read_check(16'h2000);
        poll_status(7, 1'b0, `FM_BUSY_TICKS, 2);
        stat_model.busy = 1'b0;
        read_check(16'h2001);

        // timer A, top bit set keeps the period under 512 ticks
        r = $random(seed);
        ta_load = {1'b1, r[8:0]};
        period  = 1024 - int'(ta_load);
        fm_write(`FM_REG_TA_HI, ta_load[9:2]);
        fm_write(`FM_REG_TA_LO, {6'd0, ta_load[1:0]});
        fm_write(`FM_REG_CTRL, 8'h01);
        poll_status(0, 1'b1, period, 2);
        stat_model.flag_a = 1'b1;
        fm_write(`FM_REG_CTRL, 8'h11);   // clear A, reload and keep running
        stat_model.flag_a = 1'b0;
        read_check(16'h2000);
        poll_status(0, 1'b1, period, 2);
        stat_model.flag_a = 1'b1;

        // timer B, A stops but keeps its flag
        r = $random(seed);
        tb_load = {4'hf, r[3:0]};
        period  = (256 - int'(tb_load)) * 16;
        fm_write(`FM_REG_TB, tb_load);
        fm_write(`FM_REG_CTRL, 8'h02);
        poll_status(1, 1'b1, period, 16);
        fm_write(`FM_REG_CTRL, 8'h20);   // clear B only
        stat_model.flag_b = 1'b0;
        read_check(16'h2000);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/snd_pkg.sv
logic/snd_work_ram.sv
logic/snd_irq_latch.sv
fm/fm_regs.sv
sound/snd_bus_decode.sv
sound/snd_board.sv
testbench/tb_snd_board.sv

/* run_sim.sh */
#!/bin/sh
# build the sound board testbench with Verilator and run it
# exit status is nonzero when the build or any check fails
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module tb_snd_board -o tb_snd_board &&
./obj_dir/tb_snd_board ||
{ echo "simulation did not pass"; exit 1; }
